// ==== acc_cfg.svh ====
////////////////////////////////////////////////////////////
// configuration macros for the accumulator engine
// ring sizing, memory map, mailbox words, digits and credits
////////////////////////////////////////////////////////////
`ifndef ACC_CFG_SVH
`define ACC_CFG_SVH

`define ACC_RING_SIZE    16          // coefficients per ring
`define ACC_RING_BITS    4           // index width of one ring
`define ACC_KEY_COUNT    6           // entries in the key list
`define ACC_ADDR_BITS    13          // word address width of the shared memory

// memory map, all word addresses
`define ACC_RING_BASE    13'h000
`define ACC_KEY_BASE     13'h400
`define ACC_OUT_BASE     13'h600
`define ACC_STATUS_ADDR  13'h1790    // skip count lands here
`define ACC_START_ADDR   13'h1004    // start mailbox, later overwritten with the end word
`define ACC_DONE_ADDR    13'h1789

// mailbox words
`define ACC_START_MAGIC  32'hdeadbeef
`define ACC_DONE_MAGIC   32'hd01ecafe
`define ACC_END_MAGIC    32'hbabacafe

`define ACC_DIGITS       4           // signed digits per coefficient
`define ACC_DIGIT_BITS   8
`define ACC_CREDITS      2           // words the datapath may hold at once

`endif

// ==== acc_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the accumulator engine
// sequencer states, signed digit and the memory word view
////////////////////////////////////////////////////////////
`include "acc_cfg.svh"

package acc_pkg;

    // run states of the sequencer, idle and poll_wait count as not busy
    typedef enum logic [2:0] {
        idle,
        poll_wait,
        key_req,
        key_wait,
        ring_pass,
        drain,
        write_out,
        finish
    } seq_state_t;

    // one signed digit, also one signed byte of a key entry
    typedef logic signed [`ACC_DIGIT_BITS-1:0] sdigit_t;

    // a word read back from memory is either a ring coefficient
    // or a key entry made of signed bytes, lowest byte first
    typedef union packed {
        logic [31:0]                 coeff;
        sdigit_t [`ACC_DIGITS-1:0]   key_digit;
    } mem_word_u;

endpackage

// ==== acc_sequencer.sv ====
////////////////////////////////////////////////////////////
// run state machine of the accumulator engine
// mailbox poll, key walk with zero skip, writeback start
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module acc_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      rd_valid,
    input  acc_pkg::mem_word_u        rd_data,
    input  logic                      fetch_idle,
    input  logic                      acc_idle,
    input  logic                      wb_done,
    output logic                      fetch_go,
    output logic [`ACC_ADDR_BITS-1:0] fetch_base,
    output logic [`ACC_RING_BITS:0]   fetch_count,
    output logic                      key_load,
    output logic                      key_taken,
    output logic                      acc_clear,
    output logic                      wb_go,
    output logic [31:0]               skip_count,
    output logic                      busy
);

    localparam int ENTRY_BITS = $clog2(`ACC_KEY_COUNT + 1);
    localparam logic [`ACC_RING_BITS:0] RING_LEN = `ACC_RING_SIZE;

    acc_pkg::seq_state_t   state;
    logic [ENTRY_BITS-1:0] entry;       // key list position
    logic                  hit;         // start word seen, or key entry non-zero
    logic                  fetch_out;   // a fetch command is still running
    logic                  last_entry;

    assign last_entry = (entry == ENTRY_BITS'(`ACC_KEY_COUNT - 1));
    assign busy       = !(state == acc_pkg::idle || state == acc_pkg::poll_wait);

    // single-word reads hand their credit back here, the datapath drops them
    assign key_taken = rd_valid && (state == acc_pkg::poll_wait || state == acc_pkg::key_wait);
    assign key_load  = rd_valid && state == acc_pkg::key_wait && rd_data.key_digit != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= acc_pkg::idle;
            entry       <= '0;
            hit         <= 1'b0;
            fetch_out   <= 1'b0;
            skip_count  <= '0;
            fetch_go    <= 1'b0;
            fetch_base  <= '0;
            fetch_count <= '0;
            acc_clear   <= 1'b0;
            wb_go       <= 1'b0;
        end else begin
            fetch_go  <= 1'b0;  // all commands are single-cycle pulses
            acc_clear <= 1'b0;
            wb_go     <= 1'b0;
            if (fetch_go)
                fetch_out <= 1'b1;
            else if (fetch_idle)
                fetch_out <= 1'b0;
            if (key_taken)
                hit <= (state == acc_pkg::poll_wait) ? (rd_data.coeff == `ACC_START_MAGIC)
                                                     : (rd_data.key_digit != '0);
            case (state)
                acc_pkg::idle: begin                // look at the mailbox once more
                    fetch_go    <= 1'b1;
                    fetch_base  <= `ACC_START_ADDR;
                    fetch_count <= 1;
                    state       <= acc_pkg::poll_wait;
                end
                acc_pkg::poll_wait: if (fetch_idle) begin
                    if (hit) begin                  // start word found, begin a fresh run
                        acc_clear  <= 1'b1;
                        entry      <= '0;
                        skip_count <= '0;
                        state      <= acc_pkg::key_req;
                    end else begin
                        state <= acc_pkg::idle;
                    end
                end
                acc_pkg::key_req: begin
                    fetch_go    <= 1'b1;
                    fetch_base  <= `ACC_KEY_BASE + `ACC_ADDR_BITS'(entry);
                    fetch_count <= 1;
                    state       <= acc_pkg::key_wait;
                end
                acc_pkg::key_wait: if (fetch_idle) begin
                    if (hit) begin                  // non-zero key, walk the whole ring
                        fetch_go    <= 1'b1;
                        fetch_base  <= `ACC_RING_BASE;
                        fetch_count <= RING_LEN;
                        state       <= acc_pkg::ring_pass;
                    end else begin                  // zero key adds nothing, only counted
                        skip_count <= skip_count + 1;
                        entry      <= entry + 1'b1;
                        wb_go      <= last_entry;
                        state      <= last_entry ? acc_pkg::write_out : acc_pkg::key_req;
                    end
                end
                acc_pkg::ring_pass: if (fetch_idle) state <= acc_pkg::drain;
                acc_pkg::drain: if (acc_idle) begin // last add has landed
                    entry <= entry + 1'b1;
                    wb_go <= last_entry;
                    state <= last_entry ? acc_pkg::write_out : acc_pkg::key_req;
                end
                acc_pkg::write_out: if (wb_done) state <= acc_pkg::finish;
                default: state <= acc_pkg::idle;    // finish drops busy for good
            endcase
        end
    end

    // a new command waits for the fetch unit to report the previous one done
    a_fetch_go_when_free: assert property (@(posedge clk) disable iff (reset)
        fetch_go |-> !fetch_out);

endmodule

// ==== coeff_fetch.sv ====
////////////////////////////////////////////////////////////
// read-request generator with credit flow control
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module coeff_fetch (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fetch_go,
    input  logic [`ACC_ADDR_BITS-1:0] fetch_base,
    input  logic [`ACC_RING_BITS:0]   fetch_count,
    input  logic                      rd_grant,
    input  logic                      rd_valid,
    input  logic                      credit_return,
    input  logic                      key_taken,
    output logic                      rd_req,
    output logic [`ACC_ADDR_BITS-1:0] rd_addr,
    output logic                      fetch_idle
);

    localparam int CREDIT_BITS = $clog2(`ACC_CREDITS + 1);

    logic                    active;
    logic [`ACC_RING_BITS:0] remaining;     // reads not yet granted
    logic [CREDIT_BITS-1:0]  credits;
    logic [CREDIT_BITS-1:0]  outstanding;   // granted reads whose data has not come back

    assign rd_req = active && remaining != 0 && credits != 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            active      <= 1'b0;
            remaining   <= '0;
            credits     <= CREDIT_BITS'(`ACC_CREDITS);
            outstanding <= '0;
            fetch_idle  <= 1'b0;
        end else begin
            fetch_idle  <= 1'b0;
            // a credit goes with each grant and comes back from the datapath
            // or, for single-word reads, from the sequencer
            credits     <= credits + CREDIT_BITS'(credit_return) + CREDIT_BITS'(key_taken)
                           - CREDIT_BITS'(rd_grant);
            outstanding <= outstanding + CREDIT_BITS'(rd_grant) - CREDIT_BITS'(rd_valid);
            if (fetch_go) begin
                active    <= 1'b1;
                rd_addr   <= fetch_base;
                remaining <= fetch_count;
            end else if (rd_grant) begin
                rd_addr   <= rd_addr + 1'b1;
                remaining <= remaining - 1'b1;
            end else if (active && remaining == 0 && outstanding == 0) begin
                active     <= 1'b0;     // everything has returned
                fetch_idle <= 1'b1;
            end
        end
    end

    // returns never outrun grants, whichever block hands them back
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_BITS'(`ACC_CREDITS));

endmodule

// ==== mem_arbiter.sv ====
////////////////////////////////////////////////////////////
// fixed-priority arbiter for the shared memory port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module mem_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      rd_req,
    input  logic [`ACC_ADDR_BITS-1:0] rd_addr,
    input  logic                      wr_req,
    input  logic [`ACC_ADDR_BITS-1:0] wr_addr,
    input  logic [31:0]               wr_data,
    input  logic [31:0]               mem_rdata,
    output logic                      rd_grant,
    output logic                      wr_grant,
    output logic                      rd_valid,
    output acc_pkg::mem_word_u        rd_data,
    output logic [`ACC_ADDR_BITS-1:0] mem_addr,
    output logic [31:0]               mem_wdata,
    output logic [3:0]                mem_we
);

    assign wr_grant  = wr_req;                  // the writer always wins
    assign rd_grant  = rd_req && !wr_req;
    assign mem_addr  = wr_req ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;
    assign mem_we    = wr_grant ? 4'b1111 : 4'b0000;
    assign rd_data   = mem_rdata;               // valid only while rd_valid is high

    // memory answers one cycle after the address
    always_ff @(posedge clk) begin
        if (reset)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_grant;
    end

    // fetch and writeback run in different phases, so grants never collide
    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        !(rd_req && wr_req));

endmodule

// ==== digit_decompose.sv ====
////////////////////////////////////////////////////////////
// registered balanced signed digit split of one coefficient
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module digit_decompose (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  acc_pkg::mem_word_u                 in_word,
    output logic                               out_valid,
    output acc_pkg::sdigit_t [`ACC_DIGITS-1:0] digits
);

    acc_pkg::sdigit_t [`ACC_DIGITS-1:0] split;

    // lowest digit first, a byte plus carry above half range goes negative
    // and pushes one into the next byte, the top carry is dropped
    always_comb begin
        logic [`ACC_DIGIT_BITS:0] t;
        logic                     carry;
        carry = 1'b0;
        for (int j = 0; j < `ACC_DIGITS; j++) begin
            t = {1'b0, in_word.coeff[j*`ACC_DIGIT_BITS +: `ACC_DIGIT_BITS]}
                + {{`ACC_DIGIT_BITS{1'b0}}, carry};
            split[j] = t[`ACC_DIGIT_BITS-1:0];   // same bits as t minus 256
            carry    = t[`ACC_DIGIT_BITS] | t[`ACC_DIGIT_BITS-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        digits <= split;
    end

endmodule

// ==== key_accumulate.sv ====
////////////////////////////////////////////////////////////
// key-weighted digit sum and the accumulator ring
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module key_accumulate (
    input  logic                               clk,
    input  logic                               reset,
    input  acc_pkg::sdigit_t [`ACC_DIGITS-1:0] digits,
    input  logic                               digit_valid,
    input  logic                               key_load,
    input  acc_pkg::mem_word_u                 key_word,
    input  logic                               acc_clear,
    input  logic [`ACC_RING_BITS-1:0]          rd_index,
    output logic                               credit_return,
    output logic                               acc_idle,
    output logic [31:0]                        rd_value
);

    localparam logic [`ACC_RING_BITS:0] RING_LEN = `ACC_RING_SIZE;

    logic [31:0]                        acc [`ACC_RING_SIZE];
    acc_pkg::sdigit_t [`ACC_DIGITS-1:0] key_q;      // signed bytes of the current key
    logic                               arm_q;
    logic [`ACC_RING_BITS:0]            pending;    // coefficients still owed this pass
    logic [`ACC_RING_BITS-1:0]          index;
    logic                               accept;
    logic [31:0]                        weighted;

    // words outside an armed pass (mailbox, key entries) are dropped here
    assign accept        = digit_valid && pending != 0;
    assign credit_return = accept;
    assign acc_idle      = !arm_q && pending == 0;
    assign rd_value      = acc[rd_index];

    // sum of digit times key byte, each shifted to its byte position
    always_comb begin
        logic signed [31:0] sum;
        sum = '0;
        for (int j = 0; j < `ACC_DIGITS; j++)
            sum = sum + (32'(digits[j] * key_q[j]) <<< (`ACC_DIGIT_BITS * j));
        weighted = sum;
    end

    // the pass is armed a cycle after the key load, so the key word's
    // own digits leave the decompose stage while nothing is owed
    always_ff @(posedge clk) begin
        if (reset) begin
            arm_q   <= 1'b0;
            pending <= '0;
            index   <= '0;
        end else begin
            arm_q <= key_load;
            if (arm_q)
                pending <= RING_LEN;
            else if (accept)
                pending <= pending - 1'b1;
            if (acc_clear)
                index <= '0;
            else if (accept)
                index <= index + 1'b1;  // wraps to 0 at the ring end
        end
    end

    always_ff @(posedge clk) begin
        if (key_load)
            key_q <= key_word.key_digit;
        if (acc_clear) begin
            for (int i = 0; i < `ACC_RING_SIZE; i++)
                acc[i] <= '0;
        end else if (accept) begin
            acc[index] <= acc[index] + weighted;    // mod 2^32
        end
    end

endmodule

// ==== result_writeback.sv ====
////////////////////////////////////////////////////////////
// sequential writer for ring, status, done and end words
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module result_writeback (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wb_go,
    input  logic [31:0]               skip_count,
    input  logic                      wr_grant,
    input  logic [31:0]               rd_value,
    output logic                      wr_req,
    output logic [`ACC_ADDR_BITS-1:0] wr_addr,
    output logic [31:0]               wr_data,
    output logic [`ACC_RING_BITS-1:0] rd_index,
    output logic                      wb_done
);

    localparam logic [`ACC_RING_BITS+1:0] STATUS_POS = `ACC_RING_SIZE;
    localparam logic [`ACC_RING_BITS+1:0] DONE_POS   = `ACC_RING_SIZE + 1;
    localparam logic [`ACC_RING_BITS+1:0] END_POS    = `ACC_RING_SIZE + 2;

    logic [`ACC_RING_BITS+1:0] pos;     // word being written, ring first

    assign rd_index = pos[`ACC_RING_BITS-1:0];

    // address and data follow pos, so a stalled write holds both
    always_comb begin
        case (pos)
            STATUS_POS: begin
                wr_addr = `ACC_STATUS_ADDR;
                wr_data = skip_count;
            end
            DONE_POS: begin
                wr_addr = `ACC_DONE_ADDR;
                wr_data = `ACC_DONE_MAGIC;
            end
            END_POS: begin                  // overwrite the mailbox, no restart
                wr_addr = `ACC_START_ADDR;
                wr_data = `ACC_END_MAGIC;
            end
            default: begin
                wr_addr = `ACC_OUT_BASE + `ACC_ADDR_BITS'(pos);
                wr_data = rd_value;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_req  <= 1'b0;
            pos     <= '0;
            wb_done <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            if (wb_go) begin
                wr_req <= 1'b1;
                pos    <= '0;
            end else if (wr_req && wr_grant) begin
                if (pos == END_POS) begin
                    wr_req  <= 1'b0;
                    wb_done <= 1'b1;
                end else begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

endmodule

// ==== acc_top.sv ====
////////////////////////////////////////////////////////////
// top level of the key-switching accumulator engine
// sequencer, fetch, arbiter, datapath and writeback
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module acc_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [31:0]               mem_rdata,
    output logic [`ACC_ADDR_BITS-1:0] mem_addr,
    output logic [31:0]               mem_wdata,
    output logic [3:0]                mem_we,
    output logic                      busy
);

    // fetch command and read path
    logic                      fetch_go;
    logic [`ACC_ADDR_BITS-1:0] fetch_base;
    logic [`ACC_RING_BITS:0]   fetch_count;
    logic                      fetch_idle;
    logic                      rd_req;
    logic [`ACC_ADDR_BITS-1:0] rd_addr;
    logic                      rd_grant;
    logic                      rd_valid;
    acc_pkg::mem_word_u        rd_data;

    // datapath control
    logic                      key_load;
    logic                      key_taken;
    logic                      acc_clear;
    logic                      acc_idle;
    logic                      credit_return;
    logic                      digit_valid;
    acc_pkg::sdigit_t [`ACC_DIGITS-1:0] digits;

    // writeback path
    logic                      wb_go;
    logic                      wb_done;
    logic [31:0]               skip_count;
    logic                      wr_req;
    logic                      wr_grant;
    logic [`ACC_ADDR_BITS-1:0] wr_addr;
    logic [31:0]               wr_data;
    logic [`ACC_RING_BITS-1:0] acc_index;
    logic [31:0]               acc_value;

    acc_sequencer u_seq (
        .clk(clk), .reset(reset),
        .rd_valid(rd_valid), .rd_data(rd_data),
        .fetch_idle(fetch_idle), .acc_idle(acc_idle), .wb_done(wb_done),
        .fetch_go(fetch_go), .fetch_base(fetch_base), .fetch_count(fetch_count),
        .key_load(key_load), .key_taken(key_taken), .acc_clear(acc_clear),
        .wb_go(wb_go), .skip_count(skip_count), .busy(busy)
    );

    coeff_fetch u_fetch (
        .clk(clk), .reset(reset),
        .fetch_go(fetch_go), .fetch_base(fetch_base), .fetch_count(fetch_count),
        .rd_grant(rd_grant), .rd_valid(rd_valid),
        .credit_return(credit_return), .key_taken(key_taken),
        .rd_req(rd_req), .rd_addr(rd_addr), .fetch_idle(fetch_idle)
    );

    mem_arbiter u_arb (
        .clk(clk), .reset(reset),
        .rd_req(rd_req), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .mem_rdata(mem_rdata),
        .rd_grant(rd_grant), .wr_grant(wr_grant),
        .rd_valid(rd_valid), .rd_data(rd_data),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we)
    );

    digit_decompose u_dec (
        .clk(clk), .reset(reset),
        .in_valid(rd_valid), .in_word(rd_data),
        .out_valid(digit_valid), .digits(digits)
    );

    key_accumulate u_acc (
        .clk(clk), .reset(reset),
        .digits(digits), .digit_valid(digit_valid),
        .key_load(key_load), .key_word(rd_data), .acc_clear(acc_clear),
        .rd_index(acc_index),
        .credit_return(credit_return), .acc_idle(acc_idle), .rd_value(acc_value)
    );

    result_writeback u_wb (
        .clk(clk), .reset(reset),
        .wb_go(wb_go), .skip_count(skip_count),
        .wr_grant(wr_grant), .rd_value(acc_value),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_index(acc_index), .wb_done(wb_done)
    );

endmodule

// ==== acc_tb.sv ====
////////////////////////////////////////////////////////////
// directed testbench of the accumulator engine
// shared memory model, run tasks, reference model,
// value checker and watchdog
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "acc_cfg.svh"

module acc_tb;

    localparam int  NUM_TESTS   = 5;
    localparam int  TEST_CYCLES = `ACC_KEY_COUNT * (`ACC_RING_SIZE + 8) + `ACC_RING_SIZE + 200;
    localparam int  HALF        = 1 << (`ACC_DIGIT_BITS - 1);    // first byte value that goes negative
    localparam int  RADIX       = 1 << `ACC_DIGIT_BITS;
    localparam time DRIVE_DELAY = 1;

    logic                      clk;
    logic                      reset;
    logic [31:0]               mem_rdata;
    logic [`ACC_ADDR_BITS-1:0] mem_addr;
    logic [31:0]               mem_wdata;
    logic [3:0]                mem_we;
    logic                      busy;

    logic [31:0] mem [2**`ACC_ADDR_BITS];   // the whole shared word memory
    logic [31:0] ring_in [`ACC_RING_SIZE];  // input ring of the current run
    logic [31:0] key_in [`ACC_KEY_COUNT];   // key list of the current run
    logic [31:0] lcg_state;
    int          error_count;

    acc_top DUT (
        .clk(clk), .reset(reset),
        .mem_rdata(mem_rdata), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_we(mem_we), .busy(busy)
    );

    always #10 clk = ~clk;                  // 20 ns period

    // the memory model samples the port at the edge and answers just after it
    always @(posedge clk) begin
        logic [`ACC_ADDR_BITS-1:0] addr;
        logic [31:0]               wdata;
        logic                      we;
        addr  = mem_addr;
        wdata = mem_wdata;
        we    = (mem_we == 4'hf);
        #DRIVE_DELAY;
        if (we)
            mem[addr] = wdata;
        mem_rdata = mem[addr];              // read data lines up with rd_valid
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // every address bit shows up in the background word
    function automatic logic [31:0] fill_word(int a);
        return {16'(a) ^ 16'h5a5a, ~16'(a)};
    endfunction

    task automatic fill_memory();
        for (int a = 0; a < 2**`ACC_ADDR_BITS; a++)
            mem[a] = fill_word(a);
        mem[`ACC_START_ADDR] = '0;          // an empty mailbox starts no run
    endtask

    task automatic load_ring_random();
        for (int i = 0; i < `ACC_RING_SIZE; i++)
            mem[`ACC_RING_BASE + i] = next_random();
    endtask

    // put the background back over everything the engine writes
    task automatic clear_results();
        for (int i = 0; i < `ACC_RING_SIZE; i++)
            mem[`ACC_OUT_BASE + i] = fill_word(`ACC_OUT_BASE + i);
        mem[`ACC_STATUS_ADDR] = fill_word(`ACC_STATUS_ADDR);
        mem[`ACC_DONE_ADDR]   = fill_word(`ACC_DONE_ADDR);
    endtask

    // the reference model sees the inputs as they stood before the start
    task automatic capture_inputs();
        for (int i = 0; i < `ACC_RING_SIZE; i++)
            ring_in[i] = mem[`ACC_RING_BASE + i];
        for (int e = 0; e < `ACC_KEY_COUNT; e++)
            key_in[e] = mem[`ACC_KEY_BASE + e];
    endtask

    // post the start word, then wait for the end word and for busy to drop
    task automatic run_engine();
        int cycles;
        bit seen_busy;
        cycles    = 0;
        seen_busy = 1'b0;
        capture_inputs();
        @(negedge clk);
        mem[`ACC_START_ADDR] = `ACC_START_MAGIC;
        while (mem[`ACC_START_ADDR] !== `ACC_END_MAGIC && cycles < TEST_CYCLES) begin
            @(negedge clk);
            if (busy)
                seen_busy = 1'b1;
            cycles++;
        end
        if (mem[`ACC_START_ADDR] !== `ACC_END_MAGIC) begin
            $display("the engine did not write the end word within %0d cycles", TEST_CYCLES);
            abort_run();
        end
        if (!seen_busy) begin
            $display("busy never rose while the engine was running");
            abort_run();
        end
        cycles = 0;
        while (busy && cycles < 16) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("busy stayed high after the end word was written");
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int key_byte(logic [31:0] key, int j);
        int b;
        b = key[j*`ACC_DIGIT_BITS +: `ACC_DIGIT_BITS];
        return (b >= HALF) ? b - RADIX : b;
    endfunction

    // balanced digit j with the carry rippling up from the lowest byte
    function automatic int coeff_digit(logic [31:0] c, int j);
        int carry;
        int v;
        int d;
        carry = 0;
        d     = 0;
        for (int k = 0; k <= j; k++) begin
            v = c[k*`ACC_DIGIT_BITS +: `ACC_DIGIT_BITS];
            v = v + carry;
            if (v >= HALF) begin
                d     = v - RADIX;
                carry = 1;
            end else begin
                d     = v;
                carry = 0;
            end
        end
        return d;
    endfunction

    function automatic logic [31:0] expected_coeff(int i);
        logic [31:0] sum;
        logic [31:0] term;
        logic [31:0] key;
        sum = '0;
        for (int e = 0; e < `ACC_KEY_COUNT; e++) begin
            key = key_in[e];
            if (key != '0) begin
                for (int j = 0; j < `ACC_DIGITS; j++) begin
                    term = key_byte(key, j) * coeff_digit(ring_in[i], j);
                    sum  = sum + (term << (`ACC_DIGIT_BITS * j));   // mod 2^32
                end
            end
        end
        return sum;
    endfunction

    function automatic int zero_keys();
        int n;
        n = 0;
        for (int e = 0; e < `ACC_KEY_COUNT; e++)
            if (key_in[e] == '0)
                n++;
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < `ACC_RING_SIZE; i++)
            check_value($sformatf("out_ring[%0d]", i), expected_coeff(i),
                        mem[`ACC_OUT_BASE + i]);
        check_value("status", zero_keys(), mem[`ACC_STATUS_ADDR]);
        check_value("done_word", `ACC_DONE_MAGIC, mem[`ACC_DONE_ADDR]);
        check_value("mailbox", `ACC_END_MAGIC, mem[`ACC_START_ADDR]);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    // a word one bit off the start magic must leave the engine polling
    task automatic idle_without_magic();
        @(negedge clk);
        mem[`ACC_START_ADDR] = `ACC_START_MAGIC ^ 32'h1;
        repeat (200) begin
            @(negedge clk);
            check_value("mem_we", '0, 32'(mem_we));
            check_value("busy", '0, 32'(busy));
        end
    endtask

    task automatic single_live_key();
        fill_memory();
        load_ring_random();
        for (int e = 0; e < `ACC_KEY_COUNT; e++)
            mem[`ACC_KEY_BASE + e] = '0;
        mem[`ACC_KEY_BASE + 2] = next_random() | 32'h1;  // the only live key
        run_engine();
        check_outputs();
    endtask

    task automatic mixed_zero_keys();
        fill_memory();
        load_ring_random();
        for (int e = 0; e < `ACC_KEY_COUNT; e++)
            mem[`ACC_KEY_BASE + e] = next_random() | 32'h1;
        mem[`ACC_KEY_BASE + 0] = '0;
        mem[`ACC_KEY_BASE + 3] = '0;
        mem[`ACC_KEY_BASE + 4] = '0;
        run_engine();
        check_outputs();
    endtask

    // a second run on the same inputs shows a stale accumulator as doubled values
    task automatic restart_after_done();
        fill_memory();
        load_ring_random();
        for (int e = 0; e < `ACC_KEY_COUNT; e++)
            mem[`ACC_KEY_BASE + e] = next_random() | 32'h1;
        mem[`ACC_KEY_BASE + 5] = '0;
        run_engine();
        check_outputs();
        clear_results();
        run_engine();
        check_outputs();
    endtask

    task automatic extreme_coefficients();
        logic [31:0] pick [3];
        pick[0] = 32'h7f7f7f7f;             // every byte just below the carry point
        pick[1] = 32'h80808080;             // every byte turns negative
        pick[2] = 32'hffffffff;             // carry ripples through all digits
        fill_memory();
        for (int i = 0; i < `ACC_RING_SIZE; i++)
            mem[`ACC_RING_BASE + i] = pick[i % 3];
        mem[`ACC_KEY_BASE + 0] = 32'h80808080;
        mem[`ACC_KEY_BASE + 1] = 32'h7f80807f;
        mem[`ACC_KEY_BASE + 2] = '0;
        mem[`ACC_KEY_BASE + 3] = 32'h807f7f80;
        mem[`ACC_KEY_BASE + 4] = 32'hffffff80;
        mem[`ACC_KEY_BASE + 5] = 32'h80000001;
        run_engine();
        check_outputs();
    endtask

    // watchdog sized from the worst run of every test
    initial begin
        repeat (NUM_TESTS * TEST_CYCLES + 10) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        abort_run();
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        mem_rdata   = '0;
        lcg_state   = 32'd2754;
        error_count = 0;
        fill_memory();
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        idle_without_magic();
        single_live_key();
        mixed_zero_keys();
        restart_after_done();
        extreme_coefficients();
        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "errors were found");
        end
    end

endmodule

// ==== acc_engine.f ====
+incdir+.
acc_pkg.sv
acc_sequencer.sv
coeff_fetch.sv
mem_arbiter.sv
digit_decompose.sv
key_accumulate.sv
result_writeback.sv
acc_top.sv
acc_tb.sv

// ==== Makefile ====
TOP = acc_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f acc_engine.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing -Wall -f acc_engine.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
